//--- source/fm_tone_pkg.sv
package fm_tone_pkg;

	// Datapath widths
	localparam int phase_w = 20; // Phase accumulator
	localparam int step_w = 20; // Phase step added per enabled clock
	localparam int atten_w = 7; // Attenuation register, in steps of 16 log units
	localparam int atten_shift = 4; // Attenuation is scaled by 16 before the add
	localparam int logsin_w = 12; // Log-sine value out of the decode stage
	localparam int sample_w = 14; // Signed output sample

	// Sine lookup geometry
	localparam int rom_addr_w = 5; // 32 rows
	localparam int rom_sel_w = 3; // Eight correction fields per row
	localparam int quarter_w = rom_addr_w + rom_sel_w; // Index within one quarter wave
	localparam int phase_top_w = quarter_w + 2; // Adds the mirror and sign bits
	localparam int rom_row_w = 46;
	localparam int rom_depth = 32;
	localparam int corr_w = 4; // One correction field
	localparam string rom_file = "source/sine_rows.mem";

	// Log to linear conversion
	localparam int mant_w = 8; // Fraction part of the total attenuation
	localparam int lin_w = 12; // Linear magnitude before the exponent shift

	// APB register map
	localparam int apb_addr_w = 4;
	localparam int apb_data_w = 32;
	localparam logic [apb_addr_w-1:0] addr_ctrl = 4'h0; // Bit 0 is enable
	localparam logic [apb_addr_w-1:0] addr_step = 4'h4;
	localparam logic [apb_addr_w-1:0] addr_atten = 4'h8;
	localparam logic [apb_addr_w-1:0] addr_phase = 4'hC; // Read only

	typedef struct packed {
		logic enable;
		logic [step_w-1:0] step;
		logic [atten_w-1:0] atten;
	} tone_cfg_t;

	typedef struct packed {
		logic [rom_addr_w-1:0] addr;
		logic [rom_sel_w-1:0] sel; // Picks the correction field inside the row
		logic sign; // Second half of the wave
		logic valid;
	} rom_req_t;

	typedef struct packed {
		logic [logsin_w-1:0] value;
		logic sign;
		logic valid;
	} logsin_t;

	typedef struct packed {
		logic signed [sample_w-1:0] value;
		logic valid;
	} sample_t;

endpackage

//--- source/apb_tone_regs.sv
module apb_tone_regs (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [fm_tone_pkg::apb_addr_w-1:0] paddr,
	input logic [fm_tone_pkg::apb_data_w-1:0] pwdata,
	input logic [fm_tone_pkg::phase_top_w-1:0] phase_now,
	output logic [fm_tone_pkg::apb_data_w-1:0] prdata,
	output logic pslverr,
	output fm_tone_pkg::tone_cfg_t cfg,
	output logic restart
);
	import fm_tone_pkg::*;

	logic access; // Second cycle of a transfer, where it completes
	logic addr_hit; // Address is one of the four mapped registers
	logic wr_en; // Legal write, committed on the closing edge of the access

	// No wait states, so every transfer ends in its access cycle
	assign access = psel & penable;

	always_comb
	begin
		case (paddr)
			addr_ctrl, addr_step, addr_atten, addr_phase: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	// Unmapped addresses fail, and so does any write to the phase readback
	assign pslverr = access & (~addr_hit | (pwrite & (paddr == addr_phase)));
	assign wr_en = access & pwrite & ~pslverr;

	// Only an enable going from 0 to 1 restarts the tone
	// The accumulator clears on the same edge that stores the new enable
	assign restart = wr_en & (paddr == addr_ctrl) & pwdata[0] & ~cfg.enable;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg <= '0; // Tone disabled, zero step, no attenuation
		end
		else if (wr_en)
		begin
			case (paddr)
				addr_ctrl: cfg.enable <= pwdata[0];
				addr_step: cfg.step <= pwdata[step_w-1:0];
				addr_atten: cfg.atten <= pwdata[atten_w-1:0];
				default: cfg <= cfg; // Error cases never get here
			endcase
		end
	end

	// Read data is combinational and only meaningful in the access cycle
	always_comb
	begin
		prdata = '0;
		if (access & ~pwrite)
		begin
			case (paddr)
				addr_ctrl: prdata[0] = cfg.enable;
				addr_step: prdata[step_w-1:0] = cfg.step;
				addr_atten: prdata[atten_w-1:0] = cfg.atten;
				addr_phase: prdata[phase_top_w-1:0] = phase_now; // Live upper phase bits
				default: prdata = '0;
			endcase
		end
	end

endmodule

//--- source/phase_accum.sv
module phase_accum (
	input logic clk,
	input logic rst_n,
	input fm_tone_pkg::tone_cfg_t cfg,
	input logic restart,
	output fm_tone_pkg::rom_req_t req,
	output logic [fm_tone_pkg::phase_top_w-1:0] phase_now
);
	import fm_tone_pkg::*;

	logic [phase_w-1:0] phase; // Current phase, the value being issued this cycle
	logic [phase_top_w-1:0] p; // Upper bits that address the sine
	logic [quarter_w-1:0] q; // Position inside the quarter wave after mirroring

	// Restart only ever comes while enable is still low
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= '0;
		end
		else if (restart)
		begin
			phase <= '0;
		end
		else if (cfg.enable)
		begin
			phase <= phase + cfg.step; // Wraps naturally at full scale
		end
	end

	assign p = phase[phase_w-1 -: phase_top_w];
	assign phase_now = p;

	// The second and fourth quarters run the table backwards
	always_comb
	begin
		if (p[quarter_w])
		begin
			q = ~p[quarter_w-1:0];
		end
		else
		begin
			q = p[quarter_w-1:0];
		end
	end

	always_comb
	begin
		req.addr = q[quarter_w-1:rom_sel_w]; // Row of the table
		req.sel = q[rom_sel_w-1:0]; // Correction field within the row
		req.sign = p[phase_top_w-1]; // Upper half of the period is negative
		req.valid = cfg.enable; // Every enabled cycle issues one phase
	end

endmodule

//--- source/phase_rom.sv
module phase_rom (
	input logic clk,
	input logic [fm_tone_pkg::rom_addr_w-1:0] addr,
	output logic [fm_tone_pkg::rom_row_w-1:0] row
);
	import fm_tone_pkg::*;

	// Compressed quarter-wave log-sine table
	// Each row is a 12-bit base followed by eight 4-bit corrections
	logic [rom_row_w-1:0] rows [rom_depth];

	initial
	begin
		$readmemb(rom_file, rows); // Binary rows, row 0 first
	end

	// Registered read gives the one cycle lookup latency
	always_ff @(posedge clk)
	begin
		row <= rows[addr];
	end

endmodule

//--- source/logsin_expand.sv
module logsin_expand (
	input logic clk,
	input logic rst_n,
	input fm_tone_pkg::rom_req_t req,
	input logic [fm_tone_pkg::rom_row_w-1:0] row,
	output fm_tone_pkg::logsin_t logsin
);
	import fm_tone_pkg::*;

	logic [rom_sel_w-1:0] sel_d; // Field select, aligned with the ROM output
	logic sign_d; // Sign riding along with the lookup
	logic valid_d; // Request valid, aligned with the ROM output
	logic [logsin_w-1:0] base; // Coarse log-sine for the whole row
	logic [corr_w-1:0] corr; // Fine correction picked by the low phase bits
	logic [logsin_w-1:0] sum;

	// The ROM holds its address for one cycle, so the side fields wait as well
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sel_d <= '0;
			sign_d <= 1'b0;
			valid_d <= 1'b0;
		end
		else
		begin
			sel_d <= req.sel;
			sign_d <= req.sign;
			valid_d <= req.valid;
		end
	end

	// Base sits in the top twelve bits, that is bits 45:34
	assign base = row[rom_row_w-1 -: logsin_w];

	// Field k occupies bits 4k+3 down to 4k
	// Bits 33:32 of the row carry nothing for this decode
	assign corr = row[corr_w*sel_d +: corr_w];

	assign sum = base + {{(logsin_w-corr_w){1'b0}}, corr};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			logsin <= '0;
		end
		else
		begin
			logsin.value <= sum;
			logsin.sign <= sign_d;
			logsin.valid <= valid_d; // Second stage after issue
		end
	end

endmodule

//--- source/tone_output.sv
module tone_output (
	input logic clk,
	input logic rst_n,
	input fm_tone_pkg::tone_cfg_t cfg,
	input fm_tone_pkg::logsin_t logsin,
	output fm_tone_pkg::sample_t sample
);
	import fm_tone_pkg::*;

	logic [atten_w-1:0] atten_d1; // Attenuation seen at issue time, one cycle on
	logic [atten_w-1:0] atten_d2; // Now lined up with the log-sine stage
	logic [logsin_w:0] t_sum; // One spare bit to catch overflow
	logic [logsin_w-1:0] t; // Total attenuation after saturation
	logic [lin_w-1:0] lin; // Linear mantissa from the fraction bits
	logic [lin_w-1:0] mag; // Mantissa scaled by the exponent
	logic signed [sample_w-1:0] mag_ext;
	logic signed [sample_w-1:0] value;

	// Two stages of delay keep a mid-stream write off samples already in flight
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			atten_d1 <= '0;
			atten_d2 <= '0;
		end
		else
		begin
			atten_d1 <= cfg.atten;
			atten_d2 <= atten_d1;
		end
	end

	// Attenuation counts in units of 16 on the log scale
	assign t_sum = {1'b0, logsin.value}
		+ {{(logsin_w+1-atten_w-atten_shift){1'b0}}, atten_d2, {atten_shift{1'b0}}};
	assign t = t_sum[logsin_w] ? '1 : t_sum[logsin_w-1:0]; // Clamp at 4095

	// Shift approximation of 2048 * 2^(-t/256)
	assign lin = {1'b1, {(lin_w-1){1'b0}}}
		- {1'b0, t[mant_w-1:0], {(lin_w-1-mant_w){1'b0}}};
	assign mag = lin >> t[logsin_w-1:mant_w]; // Integer part of t is the exponent

	assign mag_ext = {{(sample_w-lin_w){1'b0}}, mag};
	assign value = logsin.sign ? -mag_ext : mag_ext;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sample <= '0;
		end
		else
		begin
			sample.value <= value;
			sample.valid <= logsin.valid; // Three cycles after its phase
		end
	end

endmodule

//--- source/fm_tone.sv
module fm_tone (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [fm_tone_pkg::apb_addr_w-1:0] paddr,
	input logic [fm_tone_pkg::apb_data_w-1:0] pwdata,
	output logic [fm_tone_pkg::apb_data_w-1:0] prdata,
	output logic pslverr,
	output fm_tone_pkg::sample_t sample
);
	import fm_tone_pkg::*;

	tone_cfg_t cfg; // Enable, step and attenuation from the register file
	logic restart; // Single cycle pulse on an enable write from 0 to 1
	logic [phase_top_w-1:0] phase_now; // Readback of the running phase
	rom_req_t req; // Issued phase, split for the table lookup
	logic [rom_row_w-1:0] row;
	logsin_t logsin;

	apb_tone_regs regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.phase_now(phase_now),
		.prdata(prdata),
		.pslverr(pslverr),
		.cfg(cfg),
		.restart(restart)
	);

	phase_accum accum_i (.clk(clk), .rst_n(rst_n), .cfg(cfg), .restart(restart),
		.req(req), .phase_now(phase_now));

	phase_rom rom_i (.clk(clk), .addr(req.addr), .row(row));

	logsin_expand expand_i (.clk(clk), .rst_n(rst_n), .req(req), .row(row), .logsin(logsin));

	// Output stage picks the attenuation straight from the registers and delays it itself
	tone_output out_i (.clk(clk), .rst_n(rst_n), .cfg(cfg), .logsin(logsin), .sample(sample));

endmodule

//--- sim/fm_tone_sva.sv
module fm_tone_sva (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input fm_tone_pkg::sample_t sample
);
	import fm_tone_pkg::*;

	// An access phase always follows a setup phase with psel high
	penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> $past(psel))
		else $error("penable rose without psel in the cycle before");

	sample_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(sample.valid))
		else $error("sample valid is unknown");

	// The pipeline is three stages deep, so nothing can come out sooner
	valid_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !sample.valid ##1 !sample.valid ##1 !sample.valid)
		else $error("sample valid went high within 3 cycles of reset");

endmodule

bind fm_tone fm_tone_sva sva_i (.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
	.sample(sample));

//--- sim/fm_tone_tb.sv
module fm_tone_tb;
	import fm_tone_pkg::*;

	localparam int test_cycles = 100 + 1100 + 1700 + 200 + 200; // Rough length of all tests
	localparam int cycle_limit = test_cycles + 500;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic pslverr;
	sample_t sample;

	logic [rom_row_w-1:0] table_rows [rom_depth]; // Own copy of the sine table
	logic [31:0] lfsr = 32'h1d48_28f4;
	logic [phase_w-1:0] m_phase; // Model of the accumulator
	logic [step_w-1:0] m_step;
	logic [atten_w-1:0] m_atten;
	logic m_en;
	logic [phase_w-1:0] phase_snap; // Model phase during the last read access
	sample_t exp_q [$]; // Expected samples in issue order
	int tag_q [$]; // Cycle in which each expected sample was issued
	sample_t exp_s;
	int tag;
	int cyc = 0;
	int run_cycles = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;

	fm_tone fm_tone_i (.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pslverr(pslverr), .sample(sample));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		$readmemb(rom_file, table_rows);
	end

	// Right shifting Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr); // One step per bit taken
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Expected sample for one phase value and the attenuation in force when it issued
	function automatic sample_t model_sample(input logic [phase_w-1:0] ph,
		input logic [atten_w-1:0] att);
		logic [9:0] p;
		logic [7:0] q;
		logic [rom_row_w-1:0] r;
		int k;
		int t;
		int mag;
		sample_t s;
		p = ph[phase_w-1:phase_w-10];
		q = p[8] ? ~p[7:0] : p[7:0]; // Mirror in the second and fourth quarter
		r = table_rows[q[7:3]];
		k = int'(q[2:0]);
		t = int'(r[45:34]) + int'(r[4*k +: 4]) + int'(att) * 16;
		if (t > 4095)
			t = 4095;
		mag = (2048 - (t % 256) * 8) >> (t / 256);
		s.valid = 1'b1;
		s.value = sample_w'(p[9] ? -mag : mag);
		return s;
	endfunction

	task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("MISMATCH t=%0t %s got value=%0d valid=%b expected value=%0d valid=%b",
				$time, name, got.value, got.valid, exp.value, exp.valid);
		end
	endtask

	task automatic compare_word(input string name, input logic [apb_data_w-1:0] got,
		input logic [apb_data_w-1:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("MISMATCH t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic check_slverr(input logic [apb_addr_w-1:0] addr, input logic exp_err);
		check_cnt++;
		if (pslverr !== exp_err)
		begin
			err_cnt++;
			$display("MISMATCH t=%0t pslverr at address 0x%0h got %b expected %b",
				$time, addr, pslverr, exp_err);
		end
	endtask

	task automatic apb_write(input logic [apb_addr_w-1:0] addr,
		input logic [apb_data_w-1:0] data, input logic exp_err);
		@(negedge clk);
		psel = 1'b1; // Setup phase
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1; // Access phase, commits on the next rising edge
		#10 check_slverr(addr, exp_err);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [apb_addr_w-1:0] addr,
		output logic [apb_data_w-1:0] data, input logic exp_err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#10 check_slverr(addr, exp_err);
		data = prdata;
		phase_snap = m_phase; // Phase live during this access
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() > 0)
			@(negedge clk);
		repeat (4) @(negedge clk); // Any stray valid shows up here
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (err_cnt > err_start)
		begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, err_cnt - err_start);
		end
		else
			$display("%s: passed", name);
	endtask

	// Model of the register file and accumulator, stepped on every rising edge
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			m_phase = '0;
			m_step = '0;
			m_atten = '0;
			m_en = 1'b0;
		end
		else
		begin
			if (m_en)
			begin
				exp_q.push_back(model_sample(m_phase, m_atten)); // Issued in the cycle now ending
				tag_q.push_back(cyc);
			end
			if (psel && penable && pwrite && paddr == addr_ctrl && pwdata[0] && !m_en)
				m_phase = '0; // Restart
			else if (m_en)
				m_phase = m_phase + m_step;
			if (psel && penable && pwrite)
			begin
				case (paddr)
					addr_ctrl: m_en = pwdata[0];
					addr_step: m_step = pwdata[step_w-1:0];
					addr_atten: m_atten = pwdata[atten_w-1:0];
					default: ; // Rejected by the slave
				endcase
			end
		end
		cyc = cyc + 1;
	end

	// Pairs each valid sample with the phase issued three cycles earlier
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (sample.valid)
			begin
				if (exp_q.size() == 0)
				begin
					err_cnt++;
					$display("At t=%0t a valid sample came out with no phase issued", $time);
				end
				else
				begin
					exp_s = exp_q.pop_front();
					tag = tag_q.pop_front();
					if (cyc - tag != 3)
					begin
						err_cnt++;
						$display("At t=%0t a sample came %0d cycles after its phase instead of 3",
							$time, cyc - tag);
					end
					compare_sample("sample", sample, exp_s);
				end
			end
			else if (tag_q.size() > 0 && cyc - tag_q[0] >= 3)
			begin
				err_cnt++;
				$display("At t=%0t an issued phase produced no valid sample", $time);
				exp_s = exp_q.pop_front();
				tag = tag_q.pop_front();
			end
		end
	end

	always @(posedge clk)
	begin
		run_cycles++;
		if (run_cycles > cycle_limit)
		begin
			$display("Run stopped after %0d cycles without reaching its end", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		logic [apb_data_w-1:0] d;
		int e0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk) rst_n = 1'b1;

		// Register readback, slave errors and phase readback
		e0 = err_cnt;
		apb_write(addr_step, 32'hFFFF_F345, 1'b0);
		apb_read(addr_step, d, 1'b0);
		compare_word("prdata step", d, 32'h000F_F345); // Zero extended from 20 bits
		apb_write(addr_atten, 32'h0000_00D5, 1'b0);
		apb_read(addr_atten, d, 1'b0);
		compare_word("prdata atten", d, 32'h0000_0055);
		apb_write(4'h2, 32'hFFFF_FFFF, 1'b1);
		apb_write(addr_phase, 32'h0000_03FF, 1'b1);
		apb_read(4'hE, d, 1'b1);
		apb_read(addr_step, d, 1'b0);
		compare_word("prdata step after errors", d, 32'h000F_F345);
		apb_read(addr_atten, d, 1'b0);
		compare_word("prdata atten after errors", d, 32'h0000_0055);
		apb_read(addr_ctrl, d, 1'b0);
		compare_word("prdata ctrl after errors", d, 32'h0);
		apb_write(addr_ctrl, 32'h1, 1'b0);
		apb_read(addr_ctrl, d, 1'b0);
		compare_word("prdata ctrl", d, 32'h1);
		repeat (3)
		begin
			apb_read(addr_phase, d, 1'b0);
			compare_word("prdata phase", d, {22'b0, phase_snap[phase_w-1:phase_w-10]});
		end
		apb_write(addr_ctrl, 32'h0, 1'b0);
		wait_drain();
		end_test("test 1 registers", e0);

		// Quiet before enable, then one full slow period through all quarters
		e0 = err_cnt;
		apb_write(addr_step, 32'h400, 1'b0); // One table step per clock
		apb_write(addr_atten, 32'h0, 1'b0);
		repeat (10) @(negedge clk);
		apb_write(addr_ctrl, 32'h1, 1'b0);
		repeat (1030) @(negedge clk);
		apb_write(addr_ctrl, 32'h0, 1'b0);
		wait_drain();
		end_test("test 2 full period", e0);

		// Random steps and attenuations where the last two rounds push into saturation
		e0 = err_cnt;
		apb_write(addr_ctrl, 32'h1, 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			apb_write(addr_step, random_bits(step_w), 1'b0);
			if (i >= 6)
				apb_write(addr_atten, 32'h7F - (i - 6), 1'b0);
			else
				apb_write(addr_atten, random_bits(atten_w), 1'b0);
			repeat (200) @(negedge clk);
		end
		apb_write(addr_ctrl, 32'h0, 1'b0);
		wait_drain();
		end_test("test 3 random", e0);

		// Attenuation written while samples are in flight
		e0 = err_cnt;
		apb_write(addr_atten, 32'h0, 1'b0);
		apb_write(addr_step, 32'h1_2345, 1'b0);
		apb_write(addr_ctrl, 32'h1, 1'b0);
		repeat (50) @(negedge clk);
		apb_write(addr_atten, 32'd40, 1'b0);
		repeat (50) @(negedge clk);
		end_test("test 4 attenuation change", e0);

		// Disable drains the pipe, enable restarts at phase 0
		e0 = err_cnt;
		apb_write(addr_ctrl, 32'h0, 1'b0);
		wait_drain();
		apb_write(addr_ctrl, 32'h1, 1'b0);
		while (!sample.valid)
			@(negedge clk);
		compare_sample("first sample after restart", sample, model_sample('0, 7'd40));
		repeat (20) @(negedge clk);
		apb_write(addr_ctrl, 32'h0, 1'b0);
		wait_drain();
		end_test("test 5 disable and restart", e0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- fm_tone.f
source/fm_tone_pkg.sv
source/apb_tone_regs.sv
source/phase_accum.sv
source/phase_rom.sv
source/logsin_expand.sv
source/tone_output.sv
source/fm_tone.sv
sim/fm_tone_sva.sv
sim/fm_tone_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f fm_tone.f --top-module fm_tone_tb -o fm_tone_sim \
	&& ./obj_dir/fm_tone_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- source/sine_rows.mem
// Columns: base[45:34] unused[33:32] corr7 corr6 corr5 corr4 corr3 corr2 corr1 corr0
1000010110100000000010010001101000101011001110
0110001000000000000010010001101000101011001110
0100111110000000000010010001101000101011001110
0100001110000000000010010001101000101011001110
0011101010000000000010010001101000101011001110
0011001111000000000010010001101000101011001110
0010111001000000000010010001101000101011001110
0010100110000000000010010001101000101011001110
0010010110000000000001001000110100010101100111
0010001000000000000001001000110100010101100111
0001111100000000000001001000110100010101100111
0001110001000000000001001000110100010101100111
0001100111000000000001001000110100010101100111
0001011110000000000001001000110100010101100111
0001010110000000000001001000110100010101100111
0001001111000000000001001000110100010101100111
0001001000000000000001001000110100010101100111
0001000010000000000001001000110100010101100111
0000111100000000000001001000110100010101100111
0000110111000000000001001000110100010101100111
0000110010000000000001001000110100010101100111
0000101101000000000001001000110100010101100111
0000101001000000000001001000110100010101100111
0000100101000000000001001000110100010101100111
0000100001000000000001001000110100010101100111
0000011101000000000001001000110100010101100111
0000011001000000000001001000110100010101100111
0000010110000000000001001000110100010101100111
0000010010000000000001001000110100010101100111
0000001111000000000001001000110100010101100111
0000001100000000000001001000110100010101100111
0000001001000000000001001000110100010101100111
